// ==== build.f ====
design/isaPkg.sv
design/pipePkg.sv
design/operandDecode.sv
design/operandHazard.sv
design/issueGate.sv
design/hazardUnit.sv
test/hazardChecker.sv
test/tbHazardUnit.sv

// ==== Makefile ====
# Verilator build and run of the hazard unit testbench
# every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tbHazardUnit
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== test/tbHazardUnit.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for hazardUnit: clock, reset, directed and seeded random
// stimulus, watchdog and the closing report
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tbHazardUnit;

    localparam int PERIOD_NS = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 4;
    localparam int RANDOM_CYCLES = 2000;
    // directed block uses about 20, rounded up
    localparam int DIRECTED_CYCLES = 40;
    localparam int MARGIN_CYCLES = 50;
    localparam int TIMEOUT_NS =
        (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * PERIOD_NS;

    logic clk;
    logic rstN;
    isaPkg::instr_t fetchInst;
    pipePkg::stageInfo_t stageD;
    pipePkg::stageInfo_t stageX;
    pipePkg::stageInfo_t stageM;
    pipePkg::stageInfo_t stageW;
    isaPkg::instr_t nextInst;
    logic pcNop;
    pipePkg::fwdCtrl_t fwdA;
    pipePkg::fwdCtrl_t fwdB;
    int errCount;
    int checkCount;
    integer seed;

    hazardUnit DUT (
        .clk       (clk),
        .rstN      (rstN),
        .fetchInst (fetchInst),
        .stageD    (stageD),
        .stageX    (stageX),
        .stageM    (stageM),
        .stageW    (stageW),
        .nextInst  (nextInst),
        .pcNop     (pcNop),
        .fwdA      (fwdA),
        .fwdB      (fwdB)
    );

    hazardChecker uChecker (
        .clk        (clk),
        .rstN       (rstN),
        .fetchInst  (fetchInst),
        .stageD     (stageD),
        .stageX     (stageX),
        .stageM     (stageM),
        .stageW     (stageW),
        .nextInst   (nextInst),
        .pcNop      (pcNop),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .errCount   (errCount),
        .checkCount (checkCount)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // low 5 bits are filler immediate
    function automatic isaPkg::instr_t makeInst(isaPkg::opcode_t op,
                                                isaPkg::regIdx_t rs,
                                                isaPkg::regIdx_t rt);
        return {op, rs, rt, 5'b10101};
    endfunction

    function automatic pipePkg::stageInfo_t makeStage(logic wrt, isaPkg::regIdx_t dst,
                                                      pipePkg::wbSel_t sel, logic br);
        pipePkg::stageInfo_t s;
        s.regWrt = wrt;
        s.wrtReg = dst;
        s.wbDataSel = sel;
        s.branchInst = br;
        return s;
    endfunction

    // writers confined to r0..r3 so collisions are frequent
    function automatic pipePkg::stageInfo_t randomStage();
        pipePkg::stageInfo_t s;
        integer rnd;
        rnd = $random(seed);
        s.regWrt = rnd[0];
        s.wrtReg = {1'b0, rnd[2:1]};
        s.wbDataSel = rnd[4:3];
        // rare branches, else most cycles stall
        s.branchInst = (rnd[8:5] == 4'b0000);
        return s;
    endfunction

    function automatic isaPkg::instr_t randomInst();
        isaPkg::instr_t inst;
        integer rnd;
        rnd = $random(seed);
        inst = rnd[15:0];
        inst[isaPkg::RS_LSB +: 3] = {1'b0, rnd[17:16]};
        inst[isaPkg::RT_LSB +: 3] = {1'b0, rnd[19:18]};
        return inst;
    endfunction

    task automatic driveCycle(isaPkg::instr_t inst, pipePkg::stageInfo_t d,
                              pipePkg::stageInfo_t x, pipePkg::stageInfo_t m,
                              pipePkg::stageInfo_t w);
        @(posedge clk);
        #DRIVE_DELAY;
        fetchInst = inst;
        stageD = d;
        stageX = x;
        stageM = m;
        stageW = w;
    endtask

    initial begin : stimulus
        pipePkg::stageInfo_t idle;
        pipePkg::stageInfo_t br [4];
        isaPkg::instr_t arith;
        int k;
        seed = 19;
        idle = '0;
        arith = makeInst(isaPkg::OP_ARITH, 3'd3, 3'd4);
        // hazard present during reset, nextInst must still be a bubble
        rstN = 1'b0;
        fetchInst = arith;
        stageD = makeStage(1'b1, 3'd3, pipePkg::WB_ALU, 1'b0);
        stageX = '0;
        stageM = '0;
        stageW = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rstN = 1'b1;

        // quiet pipeline, instruction passes
        driveCycle(makeInst(isaPkg::OP_ARITH, 3'd1, 3'd2), idle, idle, idle, idle);
        // ex-to-ex on rs, mem-to-ex on the second operand, D shadows X
        driveCycle(arith, makeStage(1'b1, 3'd3, pipePkg::WB_ALU, 1'b0), idle, idle, idle);
        driveCycle(arith, idle, makeStage(1'b1, 3'd4, pipePkg::WB_IMM, 1'b0), idle, idle);
        driveCycle(arith, makeStage(1'b1, 3'd3, pipePkg::WB_ALU, 1'b0),
                   makeStage(1'b1, 3'd3, pipePkg::WB_SLBI, 1'b0), idle, idle);
        // load-use, M writer, W writer alone
        driveCycle(arith, makeStage(1'b1, 3'd3, pipePkg::WB_MEM, 1'b0), idle, idle, idle);
        driveCycle(makeInst(isaPkg::OP_ST, 3'd1, 3'd4), idle, idle,
                   makeStage(1'b1, 3'd4, pipePkg::WB_ALU, 1'b0), idle);
        driveCycle(arith, idle, idle, idle, makeStage(1'b1, 3'd3, pipePkg::WB_ALU, 1'b0));

        // one branch bit at a time in D, X, M, W
        for (k = 0; k < 4; k++) begin
            br[0] = idle;
            br[1] = idle;
            br[2] = idle;
            br[3] = idle;
            br[k].branchInst = 1'b1;
            driveCycle(makeInst(isaPkg::OP_ARITH, 3'd5, 3'd6), br[0], br[1], br[2], br[3]);
            driveCycle(makeInst(isaPkg::OP_SIIC, 3'd5, 3'd6), br[0], br[1], br[2], br[3]);
            driveCycle(makeInst(isaPkg::OP_RTI, 3'd5, 3'd6), br[0], br[1], br[2], br[3]);
        end

        // fields that are not read must not stall or forward
        driveCycle(makeInst(isaPkg::OP_LBI, 3'd3, 3'd3),
                   makeStage(1'b1, 3'd3, pipePkg::WB_MEM, 1'b0), idle,
                   makeStage(1'b1, 3'd3, pipePkg::WB_ALU, 1'b0), idle);
        driveCycle(makeInst(5'b01100, 3'd1, 3'd4), idle,
                   makeStage(1'b1, 3'd4, pipePkg::WB_ALU, 1'b0), idle, idle);
        // J ignores rs, JR reads it
        driveCycle(makeInst(5'b00100, 3'd1, 3'd0),
                   makeStage(1'b1, 3'd1, pipePkg::WB_MEM, 1'b0), idle, idle, idle);
        driveCycle(makeInst(5'b00101, 3'd1, 3'd0),
                   makeStage(1'b1, 3'd1, pipePkg::WB_MEM, 1'b0), idle, idle, idle);

        repeat (RANDOM_CYCLES) begin
            driveCycle(randomInst(), randomStage(), randomStage(), randomStage(),
                       randomStage());
        end

        // let the checker sample the last drive
        @(posedge clk);
        #1;
        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0 && checkCount > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, stimulus never finished", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== test/hazardChecker.sv ====
////////////////////////////////////////////////////////////////////////////
// hazardChecker: reference model of the hazard rules and the
// per-cycle comparison of nextInst, pcNop, fwdA and fwdB
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module hazardChecker (
    input  logic                clk,
    input  logic                rstN,
    input  isaPkg::instr_t      fetchInst,
    input  pipePkg::stageInfo_t stageD,
    input  pipePkg::stageInfo_t stageX,
    input  pipePkg::stageInfo_t stageM,
    input  pipePkg::stageInfo_t stageW,
    input  isaPkg::instr_t      nextInst,
    input  logic                pcNop,
    input  pipePkg::fwdCtrl_t   fwdA,
    input  pipePkg::fwdCtrl_t   fwdB,
    output int                  errCount,
    output int                  checkCount
);

    // which fields an opcode reads, and whether it may never stall
    typedef struct packed {
        logic rs;
        logic rt;
        logic exempt;
    } usage_t;

    // one operand's outcome
    typedef struct packed {
        logic stall;
        pipePkg::fwdCtrl_t fwd;
    } opResult_t;

    typedef struct packed {
        isaPkg::instr_t nextInst;
        logic pcNop;
        pipePkg::fwdCtrl_t fwdA;
        pipePkg::fwdCtrl_t fwdB;
    } expect_t;

    expect_t expected;

    function automatic usage_t opcodeUsage(isaPkg::opcode_t op);
        usage_t u;
        // default group reads rs only
        u.rs = 1'b1;
        u.rt = 1'b0;
        u.exempt = 1'b0;
        if (op == isaPkg::OP_SIIC || op == isaPkg::OP_RTI) begin
            u.rs = 1'b0;
            u.exempt = 1'b1;
        end else if (op == isaPkg::OP_ST || op == isaPkg::OP_STU ||
                     op == isaPkg::OP_ARITH || op == isaPkg::OP_BIT ||
                     op[4:2] == isaPkg::OP_SET) begin
            u.rt = 1'b1;
        end else if (op == isaPkg::OP_LBI || op == isaPkg::OP_HALT ||
                     op == isaPkg::OP_NOP ||
                     (op[4:2] == 3'b001 && !op[0])) begin
            // J / JAL take a displacement only
            u.rs = 1'b0;
        end
        return u;
    endfunction

    function automatic opResult_t operandRef(isaPkg::regIdx_t src, logic reads,
                                             pipePkg::stageInfo_t d,
                                             pipePkg::stageInfo_t x,
                                             pipePkg::stageInfo_t m);
        opResult_t r;
        logic hitD;
        logic hitX;
        logic hitM;
        logic loadUse;
        hitD = reads && d.regWrt && (d.wrtReg == src);
        hitX = reads && x.regWrt && (x.wrtReg == src);
        hitM = reads && m.regWrt && (m.wrtReg == src);
        loadUse = hitD && (d.wbDataSel == pipePkg::WB_MEM);
        r = '0;
        r.stall = hitM || loadUse;
        // youngest writer first, load in D never forwards
        if (loadUse) begin
            r.fwd = '0;
        end else if (hitD) begin
            r.fwd.enable = 1'b1;
            r.fwd.fromMem = 1'b0;
            r.fwd.source = d.wbDataSel;
        end else if (hitX) begin
            r.fwd.enable = 1'b1;
            r.fwd.fromMem = 1'b1;
            r.fwd.source = x.wbDataSel;
        end
        return r;
    endfunction

    function automatic expect_t expectedOutputs(isaPkg::instr_t inst, logic resetN,
                                                pipePkg::stageInfo_t d,
                                                pipePkg::stageInfo_t x,
                                                pipePkg::stageInfo_t m,
                                                pipePkg::stageInfo_t w);
        usage_t u;
        opResult_t a;
        opResult_t b;
        expect_t e;
        u = opcodeUsage(inst[isaPkg::OP_LSB +: 5]);
        a = operandRef(inst[isaPkg::RS_LSB +: 3], u.rs, d, x, m);
        b = operandRef(inst[isaPkg::RT_LSB +: 3], u.rt, d, x, m);
        e.fwdA = a.fwd;
        e.fwdB = b.fwd;
        // W writers ignored, only its branch flag counts
        e.pcNop = !u.exempt && (a.stall || b.stall || d.branchInst ||
                                x.branchInst || m.branchInst || w.branchInst);
        e.nextInst = (e.pcNop || !resetN) ? isaPkg::NOP_INSTR : inst;
        return e;
    endfunction

    task automatic checkField(string name, logic [15:0] got, logic [15:0] exp);
        if (got !== exp) begin
            errCount = errCount + 1;
            $display("ERR %0t: %s got %h expected %h (fetchInst %h)",
                     $time, name, got, exp, fetchInst);
        end
    endtask

    initial begin
        errCount = 0;
        checkCount = 0;
    end

    // inputs move 2 ns after the edge, so all values are settled here
    always @(posedge clk) begin
        expected = expectedOutputs(fetchInst, rstN, stageD, stageX, stageM, stageW);
        checkCount = checkCount + 1;
        checkField("nextInst", nextInst, expected.nextInst);
        checkField("pcNop", 16'(pcNop), 16'(expected.pcNop));
        checkField("fwdA", 16'(fwdA), 16'(expected.fwdA));
        checkField("fwdB", 16'(fwdB), 16'(expected.fwdB));
    end

endmodule

// ==== design/hazardUnit.sv ====
////////////////////////////////////////////////////////////////////////////
// hazardUnit: pipeline hazard unit top level
// opcode decode, rs and second-operand checkers, issue gate
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module hazardUnit (
    input  logic                clk,
    input  logic                rstN,
    input  isaPkg::instr_t      fetchInst,
    input  pipePkg::stageInfo_t stageD,
    input  pipePkg::stageInfo_t stageX,
    input  pipePkg::stageInfo_t stageM,
    input  pipePkg::stageInfo_t stageW,
    output isaPkg::instr_t      nextInst,
    output logic                pcNop,
    output pipePkg::fwdCtrl_t   fwdA,
    output pipePkg::fwdCtrl_t   fwdB
);

    logic readsRs;
    logic readsRt;
    logic stallExempt;
    logic stallA;
    logic stallB;

    // which fields this opcode really reads
    operandDecode uDecode (
        .opcode      (fetchInst[isaPkg::OP_LSB +: $bits(isaPkg::opcode_t)]),
        .readsRs     (readsRs),
        .readsRt     (readsRt),
        .stallExempt (stallExempt)
    );

    // operand A, rs field
    operandHazard uHazA (
        .srcReg (fetchInst[isaPkg::RS_LSB +: $bits(isaPkg::regIdx_t)]),
        .reads  (readsRs),
        .stageD (stageD),
        .stageX (stageX),
        .stageM (stageM),
        .stall  (stallA),
        .fwd    (fwdA)
    );

    // operand B, rt or rd field
    operandHazard uHazB (
        .srcReg (fetchInst[isaPkg::RT_LSB +: $bits(isaPkg::regIdx_t)]),
        .reads  (readsRt),
        .stageD (stageD),
        .stageX (stageX),
        .stageM (stageM),
        .stall  (stallB),
        .fwd    (fwdB)
    );

    // W only contributes its branch flag
    issueGate uGate (
        .clk         (clk),
        .rstN        (rstN),
        .instr       (fetchInst),
        .stallA      (stallA),
        .stallB      (stallB),
        .stallExempt (stallExempt),
        .branchBusy  ({stageD.branchInst, stageX.branchInst,
                       stageM.branchInst, stageW.branchInst}),
        .pcNop       (pcNop),
        .nextInst    (nextInst)
    );

endmodule

// ==== design/issueGate.sv ====
////////////////////////////////////////////////////////////////////////////
// final stall decision toward PC / fetch
// folds operand stalls with in-flight branches and picks instr or NOP
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module issueGate (
    input  logic           clk,
    input  logic           rstN,
    input  isaPkg::instr_t instr,
    input  logic           stallA,
    input  logic           stallB,
    input  logic           stallExempt,
    input  logic [3:0]     branchBusy,
    output logic           pcNop,
    output isaPkg::instr_t nextInst
);

    logic dataStall;
    logic ctrlStall;

    // RAW on either operand
    assign dataStall = stallA || stallB;
    // branch bits ordered D, X, M, W
    assign ctrlStall = |branchBusy;

    // SIIC / RTI always issue
    assign pcNop = !stallExempt && (dataStall || ctrlStall);

    // bubble while held or while the core is in reset
    assign nextInst = (pcNop || !rstN) ? isaPkg::NOP_INSTR : instr;

    // exempt opcodes mask the operand stalls here
    // so an operand stall on one of them would be a lost hazard
    exemptNoStall: assert property (
        @(posedge clk) stallExempt |-> !(stallA || stallB)
    ) else $error("operand stall %b%b on a stall-exempt opcode", stallA, stallB);

endmodule

// ==== design/operandHazard.sv ====
////////////////////////////////////////////////////////////////////////////
// RAW check for one source register
// load-use / M-stage stall and youngest-writer forwarding select
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module operandHazard (
    input  isaPkg::regIdx_t    srcReg,
    input  logic               reads,
    input  pipePkg::stageInfo_t stageD,
    input  pipePkg::stageInfo_t stageX,
    input  pipePkg::stageInfo_t stageM,
    output logic               stall,
    output pipePkg::fwdCtrl_t  fwd
);

    logic matchD;
    logic matchX;
    logic matchM;
    logic loadUse;

    // writer hits gated by the operand read flag
    assign matchD = reads && stageD.regWrt && (stageD.wrtReg == srcReg);
    assign matchX = reads && stageX.regWrt && (stageX.wrtReg == srcReg);
    assign matchM = reads && stageM.regWrt && (stageM.wrtReg == srcReg);

    // load one stage ahead has no data in time to bypass
    assign loadUse = matchD && (stageD.wbDataSel == pipePkg::WB_MEM);

    // M writer has no bypass path and W writes through the regfile
    assign stall = matchM || loadUse;

    always_comb begin
        fwd = '0;
        if ((matchD || matchX) && !loadUse) begin
            fwd.enable = 1'b1;
            // youngest writer wins so D shadows X
            fwd.fromMem = !matchD;
            if (matchD) begin
                fwd.source = stageD.wbDataSel;
            end else begin
                fwd.source = stageX.wbDataSel;
            end
        end
    end

endmodule

// ==== design/operandDecode.sv ====
////////////////////////////////////////////////////////////////////////////
// opcode to source-operand usage
// flags rs / second-operand reads and the stall-exempt system opcodes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module operandDecode (
    input  isaPkg::opcode_t opcode,
    output logic            readsRs,
    output logic            readsRt,
    output logic            stallExempt
);

    always_comb begin
        // most groups read rs and nothing else
        readsRs = 1'b1;
        readsRt = 1'b0;
        stallExempt = 1'b0;
        case (opcode) inside
            // trap entry and return must never be held
            isaPkg::OP_SIIC, isaPkg::OP_RTI: begin
                readsRs = 1'b0;
                stallExempt = 1'b1;
            end
            // stores read the data register too
            isaPkg::OP_ST, isaPkg::OP_STU,
            isaPkg::OP_ARITH, isaPkg::OP_BIT,
            {isaPkg::OP_SET, 2'b??}: begin
                readsRt = 1'b1;
            end
            // no register sources at all
            isaPkg::OP_LBI, isaPkg::OP_HALT, isaPkg::OP_NOP,
            isaPkg::OP_JDISP: begin
                readsRs = 1'b0;
            end
            // condition or target taken from rs
            {isaPkg::OP_BRANCH, 2'b??}, isaPkg::OP_JREG: begin
                readsRs = 1'b1;
            end
            // immediate ALU ops and loads read rs only
            default: begin
                readsRs = 1'b1;
            end
        endcase
    end

endmodule

// ==== design/pipePkg.sv ====
////////////////////////////////////////////////////////////////////////////
// pipeline bookkeeping types shared by the hazard logic
// writeback source codes, per-stage writer record, forwarding control word
////////////////////////////////////////////////////////////////////////////
package pipePkg;

    // which datapath result a stage will write back
    typedef logic [1:0] wbSel_t;

    // shifted-and-loaded immediate
    localparam wbSel_t WB_SLBI = 2'b00;
    // data memory read, only ready after M
    localparam wbSel_t WB_MEM = 2'b01;
    // ALU result
    localparam wbSel_t WB_ALU = 2'b10;
    // 8-bit immediate
    localparam wbSel_t WB_IMM = 2'b11;

    // what one downstream stage is going to do to the register file
    typedef struct packed {
        // stage will write a register
        logic regWrt;
        // destination of that write
        isaPkg::regIdx_t wrtReg;
        // source of the value being written
        wbSel_t wbDataSel;
        // stage holds a branch or jump still resolving
        logic branchInst;
    } stageInfo_t;

    // per-operand forwarding select, as the execute mux expects it
    // enable is the MSB, source the two LSBs
    typedef struct packed {
        // take the operand from the bypass network
        logic enable;
        // 0 picks the D writer (ex-to-ex)
        // 1 picks the X writer (mem-to-ex)
        logic fromMem;
        // result type carried by the chosen writer
        wbSel_t source;
    } fwdCtrl_t;

endpackage

// ==== design/isaPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction set definitions for the 16-bit, eight-register core
// word, opcode and register index types, field positions, opcode groups
// and the NOP word used as a pipeline bubble
////////////////////////////////////////////////////////////////////////////
package isaPkg;

    // raw instruction word as fetched
    typedef logic [15:0] instr_t;
    // top five bits select the opcode group
    typedef logic [4:0] opcode_t;
    // one of eight architectural registers
    typedef logic [2:0] regIdx_t;

    // field positions inside instr_t
    localparam int OP_LSB = 11;
    // rs sits in bits 10:8
    localparam int RS_LSB = 8;
    // second operand (rt or rd) sits in bits 7:5
    localparam int RT_LSB = 5;

    // memory stores
    localparam opcode_t OP_ST = 5'b10000;
    localparam opcode_t OP_STU = 5'b10011;
    // two-register ALU groups
    localparam opcode_t OP_ARITH = 5'b11011;
    localparam opcode_t OP_BIT = 5'b11010;
    // load byte immediate, writes rs only
    localparam opcode_t OP_LBI = 5'b11000;

    // system group
    localparam opcode_t OP_HALT = 5'b00000;
    localparam opcode_t OP_NOP = 5'b00001;
    localparam opcode_t OP_SIIC = 5'b00010;
    localparam opcode_t OP_RTI = 5'b00011;

    // set-on-compare, low two bits pick the compare
    localparam logic [2:0] OP_SET = 3'b111;
    // conditional branches on rs
    localparam logic [2:0] OP_BRANCH = 3'b011;
    // JR / JALR, target from rs
    localparam opcode_t OP_JREG = 5'b001?1;
    // J / JAL, pc-relative displacement only
    localparam opcode_t OP_JDISP = 5'b001?0;

    // bubble word, NOP opcode with all other fields clear
    localparam instr_t NOP_INSTR = {OP_NOP, 11'b0};

endpackage
